//--- logic/csr_map_pkg.sv
package csr_map_pkg;

    localparam int CSR_AW = 12;
    localparam int XLEN   = 32;

    // machine level
    localparam logic [CSR_AW-1:0] ADDR_MSTATUS  = 12'h300;
    localparam logic [CSR_AW-1:0] ADDR_MISA     = 12'h301;
    localparam logic [CSR_AW-1:0] ADDR_MEDELEG  = 12'h302;
    localparam logic [CSR_AW-1:0] ADDR_MIDELEG  = 12'h303;
    localparam logic [CSR_AW-1:0] ADDR_MIE      = 12'h304;
    localparam logic [CSR_AW-1:0] ADDR_MTVEC    = 12'h305;
    localparam logic [CSR_AW-1:0] ADDR_MSCRATCH = 12'h340;
    localparam logic [CSR_AW-1:0] ADDR_MEPC     = 12'h341;
    localparam logic [CSR_AW-1:0] ADDR_MCAUSE   = 12'h342;
    localparam logic [CSR_AW-1:0] ADDR_MTVAL    = 12'h343;
    localparam logic [CSR_AW-1:0] ADDR_MIP      = 12'h344;
    // supervisor level
    localparam logic [CSR_AW-1:0] ADDR_SSTATUS  = 12'h100;
    localparam logic [CSR_AW-1:0] ADDR_SIE      = 12'h104;
    localparam logic [CSR_AW-1:0] ADDR_STVEC    = 12'h105;
    localparam logic [CSR_AW-1:0] ADDR_SSCRATCH = 12'h140;
    localparam logic [CSR_AW-1:0] ADDR_SEPC     = 12'h141;
    localparam logic [CSR_AW-1:0] ADDR_SCAUSE   = 12'h142;
    localparam logic [CSR_AW-1:0] ADDR_STVAL    = 12'h143;
    localparam logic [CSR_AW-1:0] ADDR_SIP      = 12'h144;
    localparam logic [CSR_AW-1:0] ADDR_SATP     = 12'h180;

    localparam logic [XLEN-1:0] MASK_MSTATUS  = 32'h0004_19aa; // sie mie spie mpie spp mpp sum
    localparam logic [XLEN-1:0] MASK_SSTATUS  = 32'h0004_0122; // sie spie spp sum
    localparam logic [XLEN-1:0] MASK_MISA     = 32'hc3ff_ffff;
    localparam logic [XLEN-1:0] MASK_MEDELEG  = 32'h0000_f7ff; // no ecall from M
    localparam logic [XLEN-1:0] MASK_MIDELEG  = 32'h0000_0222;
    localparam logic [XLEN-1:0] MASK_MIE      = 32'h0000_0aaa;
    localparam logic [XLEN-1:0] MASK_MIP      = 32'h0000_0aaa;
    localparam logic [XLEN-1:0] MASK_SIE      = 32'h0000_0222;
    localparam logic [XLEN-1:0] MASK_SIP      = 32'h0000_0222;
    localparam logic [XLEN-1:0] MASK_TVEC     = 32'hffff_fffc; // direct mode only
    localparam logic [XLEN-1:0] MASK_EPC      = 32'hffff_fffe;
    localparam logic [XLEN-1:0] MASK_CAUSE    = 32'h8000_001f;
    localparam logic [XLEN-1:0] MASK_FULL     = 32'hffff_ffff; // scratch, tval, satp

    typedef enum logic [1:0] {
        PRIV_U = 2'b00,
        PRIV_S = 2'b01,
        PRIV_M = 2'b11
    } priv_t;

    typedef struct packed {
        logic [12:0] wpri_31_19;
        logic        sum;
        logic [4:0]  wpri_17_13;
        logic [1:0]  mpp;
        logic [1:0]  wpri_10_9;
        logic        spp;
        logic        mpie;
        logic        wpri_6;
        logic        spie;
        logic        wpri_4;
        logic        mie;
        logic        wpri_2;
        logic        sie;
        logic        wpri_0;
    } mstatus_fields_t;

    // raw word for csr access, fields for trap and return
    typedef union packed {
        logic [XLEN-1:0] raw;
        mstatus_fields_t f;
    } mstatus_u;

    typedef struct packed {
        priv_t           priv;
        mstatus_u        mstatus;
        logic [XLEN-1:0] misa;
        logic [XLEN-1:0] medeleg;
        logic [XLEN-1:0] mideleg;
        logic [XLEN-1:0] mie;
        logic [XLEN-1:0] mip;
        logic [XLEN-1:0] mtvec;
        logic [XLEN-1:0] mscratch;
        logic [XLEN-1:0] mepc;
        logic [XLEN-1:0] mcause;
        logic [XLEN-1:0] mtval;
        logic [XLEN-1:0] stvec;
        logic [XLEN-1:0] sscratch;
        logic [XLEN-1:0] sepc;
        logic [XLEN-1:0] scause;
        logic [XLEN-1:0] stval;
        logic [XLEN-1:0] satp;
    } csr_state_t;

endpackage

//--- logic/trap_pkg.sv
package trap_pkg;

    // exception codes as in mcause
    typedef logic [4:0] cause_t;

    localparam cause_t CAUSE_MISALIGNED_PC   = 5'd0;
    localparam cause_t CAUSE_ACCESS_FAULT    = 5'd1;
    localparam cause_t CAUSE_ILLEGAL_INST    = 5'd2;
    localparam cause_t CAUSE_BREAKPOINT      = 5'd3;
    localparam cause_t CAUSE_ECALL_U         = 5'd8;
    localparam cause_t CAUSE_ECALL_S         = 5'd9;
    localparam cause_t CAUSE_ECALL_M         = 5'd11;
    localparam cause_t CAUSE_INST_PAGE_FAULT = 5'd12;

    typedef struct packed {
        logic                              trap;  // cause field is valid
        logic                              ecall; // cause from priv instead
        logic                              mret;
        logic                              sret;
        cause_t                            cause;
        logic [csr_map_pkg::XLEN-1:0]      pc;
        logic [csr_map_pkg::XLEN-1:0]      inst;
    } trap_req_t;

    typedef enum logic [2:0] {
        UPD_NONE,
        UPD_TRAP_M,
        UPD_TRAP_S,
        UPD_MRET,
        UPD_SRET
    } upd_kind_t;

    typedef struct packed {
        upd_kind_t                    kind;
        cause_t                       cause;
        logic [csr_map_pkg::XLEN-1:0] epc;
        logic [csr_map_pkg::XLEN-1:0] tval;
        csr_map_pkg::priv_t           priv; // privilege after the edge
    } trap_update_t;

    typedef struct packed {
        logic                         valid;
        logic [csr_map_pkg::XLEN-1:0] target;
    } redirect_t;

endpackage

//--- logic/csr_regs.sv
`timescale 1ns/1ns

module csr_regs (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               wen,
    input  logic [csr_map_pkg::CSR_AW-1:0]     waddr,
    input  logic [csr_map_pkg::XLEN-1:0]       wdata,
    input  trap_pkg::trap_update_t             upd,
    output csr_map_pkg::csr_state_t            state
);

    csr_map_pkg::csr_state_t nxt;

    // keep the bits outside the mask, take the rest from wdata
    function automatic logic [csr_map_pkg::XLEN-1:0] merge(
        input logic [csr_map_pkg::XLEN-1:0] old,
        input logic [csr_map_pkg::XLEN-1:0] data,
        input logic [csr_map_pkg::XLEN-1:0] mask
    );
        return (old & ~mask) | (data & mask);
    endfunction

    always_comb begin
        nxt = state;
        case (upd.kind)
            trap_pkg::UPD_TRAP_M: begin
                nxt.mstatus.f.mpie = state.mstatus.f.mie;
                nxt.mstatus.f.mpp  = state.priv;
                nxt.mstatus.f.mie  = 1'b0;
                nxt.mepc           = upd.epc;
                nxt.mcause         = {{(csr_map_pkg::XLEN-5){1'b0}}, upd.cause};
                nxt.mtval          = upd.tval;
                nxt.priv           = upd.priv;
            end
            trap_pkg::UPD_TRAP_S: begin
                nxt.mstatus.f.spie = state.mstatus.f.sie;
                nxt.mstatus.f.spp  = state.priv[0]; // only U or S get here
                nxt.mstatus.f.sie  = 1'b0;
                nxt.sepc           = upd.epc;
                nxt.scause         = {{(csr_map_pkg::XLEN-5){1'b0}}, upd.cause};
                nxt.stval          = upd.tval;
                nxt.priv           = upd.priv;
            end
            trap_pkg::UPD_MRET: begin
                nxt.priv           = upd.priv; // resolved from mpp
                nxt.mstatus.f.mie  = state.mstatus.f.mpie;
                nxt.mstatus.f.mpie = 1'b1;
                nxt.mstatus.f.mpp  = csr_map_pkg::PRIV_U;
            end
            trap_pkg::UPD_SRET: begin
                nxt.priv           = upd.priv;
                nxt.mstatus.f.sie  = state.mstatus.f.spie;
                nxt.mstatus.f.spie = 1'b1;
                nxt.mstatus.f.spp  = 1'b0;
            end
            default: begin
                // software write only when no trap or return this cycle
                if (wen) begin
                    case (waddr)
                        csr_map_pkg::ADDR_MSTATUS: nxt.mstatus.raw =
                            merge(state.mstatus.raw, wdata, csr_map_pkg::MASK_MSTATUS);
                        csr_map_pkg::ADDR_SSTATUS: nxt.mstatus.raw =
                            merge(state.mstatus.raw, wdata, csr_map_pkg::MASK_SSTATUS);
                        csr_map_pkg::ADDR_MISA:
                            nxt.misa = merge(state.misa, wdata, csr_map_pkg::MASK_MISA);
                        csr_map_pkg::ADDR_MEDELEG:
                            nxt.medeleg = merge(state.medeleg, wdata, csr_map_pkg::MASK_MEDELEG);
                        csr_map_pkg::ADDR_MIDELEG:
                            nxt.mideleg = merge(state.mideleg, wdata, csr_map_pkg::MASK_MIDELEG);
                        csr_map_pkg::ADDR_MIE:
                            nxt.mie = merge(state.mie, wdata, csr_map_pkg::MASK_MIE);
                        csr_map_pkg::ADDR_SIE:
                            nxt.mie = merge(state.mie, wdata, csr_map_pkg::MASK_SIE);
                        csr_map_pkg::ADDR_MIP:
                            nxt.mip = merge(state.mip, wdata, csr_map_pkg::MASK_MIP);
                        csr_map_pkg::ADDR_SIP:
                            nxt.mip = merge(state.mip, wdata, csr_map_pkg::MASK_SIP);
                        csr_map_pkg::ADDR_MTVEC:
                            nxt.mtvec = merge(state.mtvec, wdata, csr_map_pkg::MASK_TVEC);
                        csr_map_pkg::ADDR_STVEC:
                            nxt.stvec = merge(state.stvec, wdata, csr_map_pkg::MASK_TVEC);
                        csr_map_pkg::ADDR_MSCRATCH:
                            nxt.mscratch = merge(state.mscratch, wdata, csr_map_pkg::MASK_FULL);
                        csr_map_pkg::ADDR_SSCRATCH:
                            nxt.sscratch = merge(state.sscratch, wdata, csr_map_pkg::MASK_FULL);
                        csr_map_pkg::ADDR_MEPC:
                            nxt.mepc = merge(state.mepc, wdata, csr_map_pkg::MASK_EPC);
                        csr_map_pkg::ADDR_SEPC:
                            nxt.sepc = merge(state.sepc, wdata, csr_map_pkg::MASK_EPC);
                        csr_map_pkg::ADDR_MCAUSE:
                            nxt.mcause = merge(state.mcause, wdata, csr_map_pkg::MASK_CAUSE);
                        csr_map_pkg::ADDR_SCAUSE:
                            nxt.scause = merge(state.scause, wdata, csr_map_pkg::MASK_CAUSE);
                        csr_map_pkg::ADDR_MTVAL:
                            nxt.mtval = merge(state.mtval, wdata, csr_map_pkg::MASK_FULL);
                        csr_map_pkg::ADDR_STVAL:
                            nxt.stval = merge(state.stval, wdata, csr_map_pkg::MASK_FULL);
                        csr_map_pkg::ADDR_SATP:
                            nxt.satp = merge(state.satp, wdata, csr_map_pkg::MASK_FULL);
                        default: ; // writes to unknown addresses are dropped
                    endcase
                end
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= '0;
            state.priv <= csr_map_pkg::PRIV_M; // boot in machine mode
        end else begin
            state <= nxt;
        end
    end

endmodule

//--- logic/csr_read_mux.sv
`timescale 1ns/1ns

module csr_read_mux (
    input  logic                           ren,
    input  logic [csr_map_pkg::CSR_AW-1:0] raddr,
    input  csr_map_pkg::csr_state_t        state,
    output logic [csr_map_pkg::XLEN-1:0]   rdata
);

    always_comb begin
        rdata = '0;
        if (ren) begin
            case (raddr)
                csr_map_pkg::ADDR_MSTATUS:
                    rdata = state.mstatus.raw & csr_map_pkg::MASK_MSTATUS;
                csr_map_pkg::ADDR_MISA:     rdata = state.misa & csr_map_pkg::MASK_MISA;
                csr_map_pkg::ADDR_MEDELEG:  rdata = state.medeleg & csr_map_pkg::MASK_MEDELEG;
                csr_map_pkg::ADDR_MIDELEG:  rdata = state.mideleg & csr_map_pkg::MASK_MIDELEG;
                csr_map_pkg::ADDR_MIE:      rdata = state.mie & csr_map_pkg::MASK_MIE;
                csr_map_pkg::ADDR_MIP:      rdata = state.mip & csr_map_pkg::MASK_MIP;
                csr_map_pkg::ADDR_MTVEC:    rdata = state.mtvec & csr_map_pkg::MASK_TVEC;
                csr_map_pkg::ADDR_MSCRATCH: rdata = state.mscratch & csr_map_pkg::MASK_FULL;
                csr_map_pkg::ADDR_MEPC:     rdata = state.mepc & csr_map_pkg::MASK_EPC;
                csr_map_pkg::ADDR_MCAUSE:   rdata = state.mcause & csr_map_pkg::MASK_CAUSE;
                csr_map_pkg::ADDR_MTVAL:    rdata = state.mtval & csr_map_pkg::MASK_FULL;

                // supervisor windows onto the machine registers
                csr_map_pkg::ADDR_SSTATUS:
                    rdata = state.mstatus.raw & csr_map_pkg::MASK_SSTATUS;
                csr_map_pkg::ADDR_SIE:      rdata = state.mie & csr_map_pkg::MASK_SIE;
                csr_map_pkg::ADDR_SIP:      rdata = state.mip & csr_map_pkg::MASK_SIP;

                csr_map_pkg::ADDR_STVEC:    rdata = state.stvec & csr_map_pkg::MASK_TVEC;
                csr_map_pkg::ADDR_SSCRATCH: rdata = state.sscratch & csr_map_pkg::MASK_FULL;
                csr_map_pkg::ADDR_SEPC:     rdata = state.sepc & csr_map_pkg::MASK_EPC;
                csr_map_pkg::ADDR_SCAUSE:   rdata = state.scause & csr_map_pkg::MASK_CAUSE;
                csr_map_pkg::ADDR_STVAL:    rdata = state.stval & csr_map_pkg::MASK_FULL;
                csr_map_pkg::ADDR_SATP:     rdata = state.satp & csr_map_pkg::MASK_FULL;
                default:                    rdata = '0; // unimplemented csr
            endcase
        end
    end

endmodule

//--- logic/trap_ctrl.sv
`timescale 1ns/1ns

module trap_ctrl (
    input  logic                         clk,
    input  logic                         rst,
    input  trap_pkg::trap_req_t          req,
    input  csr_map_pkg::csr_state_t      state,
    output trap_pkg::trap_update_t       upd,
    output trap_pkg::redirect_t          redirect
);

    logic                         take;       // trap or ecall this cycle
    logic                         deleg;
    trap_pkg::cause_t             cause_eff;
    logic [csr_map_pkg::XLEN-1:0] tval;
    logic [csr_map_pkg::XLEN-1:0] nxt_target;

    assign take = req.trap | req.ecall;

    // ecall code depends on the privilege it was issued from
    always_comb begin
        cause_eff = req.cause;
        if (req.ecall) begin
            case (state.priv)
                csr_map_pkg::PRIV_U: cause_eff = trap_pkg::CAUSE_ECALL_U;
                csr_map_pkg::PRIV_S: cause_eff = trap_pkg::CAUSE_ECALL_S;
                default:             cause_eff = trap_pkg::CAUSE_ECALL_M;
            endcase
        end
    end

    // M never delegates downward
    assign deleg = state.medeleg[cause_eff] && (state.priv != csr_map_pkg::PRIV_M);

    always_comb begin
        case (cause_eff)
            trap_pkg::CAUSE_MISALIGNED_PC,
            trap_pkg::CAUSE_ACCESS_FAULT,
            trap_pkg::CAUSE_BREAKPOINT,
            trap_pkg::CAUSE_INST_PAGE_FAULT: tval = req.pc;
            trap_pkg::CAUSE_ILLEGAL_INST:    tval = req.inst; // offending encoding
            default:                         tval = '0;
        endcase
    end

    always_comb begin
        upd        = '0;
        upd.kind   = trap_pkg::UPD_NONE;
        upd.priv   = state.priv;
        nxt_target = '0;
        if (take) begin
            upd.cause = cause_eff;
            upd.epc   = req.pc;
            upd.tval  = tval;
            if (deleg) begin
                upd.kind   = trap_pkg::UPD_TRAP_S;
                upd.priv   = csr_map_pkg::PRIV_S;
                nxt_target = state.stvec;
            end else begin
                upd.kind   = trap_pkg::UPD_TRAP_M;
                upd.priv   = csr_map_pkg::PRIV_M;
                nxt_target = state.mtvec;
            end
        end else if (req.mret) begin
            upd.kind   = trap_pkg::UPD_MRET;
            upd.priv   = csr_map_pkg::priv_t'(state.mstatus.f.mpp);
            nxt_target = state.mepc;
        end else if (req.sret) begin
            upd.kind   = trap_pkg::UPD_SRET;
            upd.priv   = state.mstatus.f.spp ? csr_map_pkg::PRIV_S : csr_map_pkg::PRIV_U;
            nxt_target = state.sepc;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            redirect <= '0;
        end else begin
            redirect.valid  <= (upd.kind != trap_pkg::UPD_NONE);
            redirect.target <= nxt_target; // state as it was before the edge
        end
    end

endmodule

//--- logic/csr_unit.sv
`timescale 1ns/1ns

module csr_unit (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           wen,
    input  logic [csr_map_pkg::CSR_AW-1:0] waddr,
    input  logic [csr_map_pkg::XLEN-1:0]   wdata,
    input  logic                           ren,
    input  logic [csr_map_pkg::CSR_AW-1:0] raddr,
    input  trap_pkg::trap_req_t            req,
    output logic [csr_map_pkg::XLEN-1:0]   rdata,
    output trap_pkg::redirect_t            redirect,
    output csr_map_pkg::priv_t             priv,
    output logic [csr_map_pkg::XLEN-1:0]   satp,
    output logic                           sum
);

    csr_map_pkg::csr_state_t state;
    trap_pkg::trap_update_t  upd;

    trap_ctrl ctrl_i (
        .clk      (clk),
        .rst      (rst),
        .req      (req),
        .state    (state),
        .upd      (upd),
        .redirect (redirect)
    );

    csr_regs regs_i (
        .clk   (clk),
        .rst   (rst),
        .wen   (wen),
        .waddr (waddr),
        .wdata (wdata),
        .upd   (upd),
        .state (state)
    );

    csr_read_mux rmux_i (
        .ren   (ren),
        .raddr (raddr),
        .state (state),
        .rdata (rdata)
    );

    // mmu side
    assign priv = state.priv;
    assign satp = state.satp;
    assign sum  = state.mstatus.f.sum;

endmodule

//--- verif/csr_checker.sv
`timescale 1ns/1ns

module csr_checker (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         go,      // a check starts this cycle
    input  string                        op,
    input  string                        name,
    input  logic [31:0]                  exp,
    input  logic [31:0]                  rdata,
    input  trap_pkg::redirect_t          redirect,
    input  csr_map_pkg::priv_t           priv,
    input  logic [31:0]                  satp,
    input  logic                         sum,
    output int                           done_cnt,
    output int                           pass_cnt,
    output int                           fail_cnt
);

    localparam int REDIR_TIMEOUT = 20; // cycles

    task automatic compare(input logic [31:0] act);
        if (act === exp) begin
            pass_cnt++;
            $display("pass     %-14s value %h", name, act);
        end else begin
            fail_cnt++;
            $display("mismatch %-14s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic report_error(input string msg);
        fail_cnt++;
        $display("error    %-14s %s", name, msg);
    endtask

    // redirect comes one cycle after the request, and for one cycle only
    task automatic check_redirect();
        int   n;
        logic seen;
        seen = 1'b0;
        n    = 0;
        while (!seen && n < REDIR_TIMEOUT) begin
            @(negedge clk);
            n++;
            if (redirect.valid) seen = 1'b1;
        end
        if (!seen) begin
            report_error("redirect never asserted");
        end else if (n != 1) begin
            report_error("redirect came later than the cycle after the request");
        end else begin
            compare(redirect.target);
            @(negedge clk);
            if (redirect.valid) report_error("redirect held for more than one cycle");
        end
    endtask

    always @(negedge clk) begin
        if (rst) begin
            done_cnt = 0;
            pass_cnt = 0;
            fail_cnt = 0;
        end else if (go) begin
            case (op)
                "read":  compare(rdata);
                "priv":  compare({30'b0, priv});
                "satp":  compare(satp);
                "sum":   compare({31'b0, sum});
                "rdv":   compare({31'b0, redirect.valid});
                "trap", "ecall", "mret", "sret": check_redirect();
                default: report_error("unknown check requested");
            endcase
            done_cnt++;
        end
    end

endmodule

//--- verif/csr_tb.sv
`timescale 1ns/1ns

module csr_tb;

    localparam int DONE_TIMEOUT = 50;

    logic                           clk;
    logic                           rst;
    logic                           wen;
    logic [csr_map_pkg::CSR_AW-1:0] waddr;
    logic [csr_map_pkg::XLEN-1:0]   wdata;
    logic                           ren;
    logic [csr_map_pkg::CSR_AW-1:0] raddr;
    trap_pkg::trap_req_t            req;
    logic [csr_map_pkg::XLEN-1:0]   rdata;
    trap_pkg::redirect_t            redirect;
    csr_map_pkg::priv_t             priv;
    logic [csr_map_pkg::XLEN-1:0]   satp;
    logic                           sum;

    logic        go;
    string       chk_op;
    string       chk_name;
    logic [31:0] chk_exp;
    int          done_cnt;
    int          pass_cnt;
    int          fail_cnt;
    int          tb_err;
    logic [31:0] rnd_val;

    csr_unit dut_i (
        .clk(clk), .rst(rst), .wen(wen), .waddr(waddr), .wdata(wdata),
        .ren(ren), .raddr(raddr), .req(req), .rdata(rdata),
        .redirect(redirect), .priv(priv), .satp(satp), .sum(sum)
    );

    csr_checker chk_i (
        .clk(clk), .rst(rst), .go(go), .op(chk_op), .name(chk_name), .exp(chk_exp),
        .rdata(rdata), .redirect(redirect), .priv(priv), .satp(satp), .sum(sum),
        .done_cnt(done_cnt), .pass_cnt(pass_cnt), .fail_cnt(fail_cnt)
    );

    always #20 clk = ~clk;

    function automatic logic [31:0] lcg(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic idle_inputs();
        wen   = 1'b0;
        waddr = '0;
        wdata = '0;
        ren   = 1'b0;
        raddr = '0;
        req   = '0;
        go    = 1'b0;
    endtask

    // drive one stim line for a cycle, then wait for the checker
    task automatic run_line(input string name, input string op, input logic [31:0] a,
                            input string bstr, input logic [31:0] c, input string estr);
        logic [31:0] data;
        logic [31:0] exp;
        int          prev;
        int          n;
        data = '0;
        exp  = '0;
        if (bstr == "rnd") begin
            rnd_val = lcg(rnd_val);
            data    = rnd_val;
        end else if ($sscanf(bstr, "%h", data) != 1) begin
            data = '0;
        end
        if (estr == "rnd") exp = rnd_val;
        else if ($sscanf(estr, "%h", exp) != 1) exp = '0;

        @(posedge clk);
        #2;
        idle_inputs();
        case (op)
            "write": begin
                wen   = 1'b1;
                waddr = a[11:0];
                wdata = data;
            end
            "read": begin
                ren   = 1'b1;
                raddr = a[11:0];
            end
            "trap": begin
                req.trap  = 1'b1;
                req.cause = a[4:0];
                req.pc    = data;
                req.inst  = c;
            end
            "ecall": begin
                req.ecall = 1'b1;
                req.pc    = data;
            end
            "mret":  req.mret = 1'b1;
            "sret":  req.sret = 1'b1;
            "priv", "satp", "sum", "rdv": ;
            default: begin
                tb_err++;
                $display("error    %-14s unknown operation %s in stimulus", name, op);
            end
        endcase
        chk_op   = op;
        chk_name = name;
        chk_exp  = exp;
        go       = (op != "write");
        prev     = done_cnt;
        @(posedge clk);
        #2;
        if (go) begin
            idle_inputs();
            n = 0;
            while (done_cnt == prev && n < DONE_TIMEOUT) begin
                @(posedge clk);
                n++;
            end
            if (done_cnt == prev) begin
                tb_err++;
                $display("error    %-14s checker never finished the test", name);
            end
        end else begin
            idle_inputs();
        end
    endtask

    initial begin
        int    fd;
        string line;
        string name;
        string op;
        string bstr;
        string estr;
        logic [31:0] a;
        logic [31:0] c;
        clk     = 1'b0;
        rst     = 1'b1;
        tb_err  = 0;
        rnd_val = 32'hb049; // lcg seed
        chk_op   = "";
        chk_name = "";
        chk_exp  = '0;
        idle_inputs();
        repeat (4) @(posedge clk);
        #2;
        rst = 1'b0;

        fd = $fopen("verif/csr_stim.txt", "r");
        if (fd == 0) begin
            tb_err++;
            $display("error    could not open the stimulus file");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                if ($fgets(line, fd) != 0) begin
                    if ($sscanf(line, "%s %s %h %s %h %s", name, op, a, bstr, c, estr) == 6
                        && name != "#") begin
                        run_line(name, op, a, bstr, c, estr);
                    end
                end
            end
            $fclose(fd);
        end

        $display("tests passed %0d, failed %0d, other errors %0d", pass_cnt, fail_cnt, tb_err);
        if (fail_cnt == 0 && tb_err == 0 && pass_cnt > 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

//--- verif/csr_stim.txt
# name op addr_or_cause data_or_pc inst expected, numbers in hex
# rnd as data takes the next lcg word, rnd as expected the last one
rst_mstatus   read  300 0        0        00000000
rst_misa      read  301 0        0        00000000
rst_medeleg   read  302 0        0        00000000
rst_mie       read  304 0        0        00000000
rst_mtvec     read  305 0        0        00000000
rst_mepc      read  341 0        0        00000000
rst_mcause    read  342 0        0        00000000
rst_stvec     read  105 0        0        00000000
rst_sepc      read  141 0        0        00000000
rst_satp      read  180 0        0        00000000
rst_priv      priv  0   0        0        00000003
rst_redir     rdv   0   0        0        00000000
wr_mstatus    write 300 ffffffff 0        0
mstatus_mask  read  300 0        0        000419aa
sstatus_mask  read  100 0        0        00040122
sum_on        sum   0   0        0        00000001
wr_sstatus    write 100 00000000 0        0
mstatus_kept  read  300 0        0        00001888
sum_off       sum   0   0        0        00000000
unknown_addr  read  7c0 0        0        00000000
wr_mscratch   write 340 rnd      0        0
mscratch_rnd  read  340 0        0        rnd
wr_sscratch   write 140 rnd      0        0
sscratch_rnd  read  140 0        0        rnd
wr_satp       write 180 80001234 0        0
satp_out      satp  0   0        0        80001234
wr_mtvec      write 305 00001003 0        0
trap_illegal  trap  2   00000400 deadbeef 00001000
mepc_trap     read  341 0        0        00000400
mcause_trap   read  342 0        0        00000002
mtval_inst    read  343 0        0        deadbeef
mstatus_trap  read  300 0        0        00001880
priv_trap     priv  0   0        0        00000003
trap_brk      trap  3   00000500 0        00001000
mtval_pc      read  343 0        0        00000500
mstatus_brk   read  300 0        0        00001800
wr_mpp_u      write 300 00000080 0        0
wr_mepc       write 341 00002000 0        0
mret_go       mret  0   0        0        00002000
priv_mret     priv  0   0        0        00000000
mstatus_mret  read  300 0        0        00000088
wr_medeleg    write 302 00000100 0        0
medeleg_rd    read  302 0        0        00000100
wr_stvec      write 105 00003000 0        0
ecall_deleg   ecall 0   00000600 0        00003000
scause_ecall  read  142 0        0        00000008
sepc_ecall    read  141 0        0        00000600
stval_ecall   read  143 0        0        00000000
priv_deleg    priv  0   0        0        00000001
sret_go       sret  0   0        0        00000600
priv_sret     priv  0   0        0        00000000
sstatus_sret  read  100 0        0        00000020
wr_sum        write 100 00040020 0        0
sum_follow    sum   0   0        0        00000001
end_redir     rdv   0   0        0        00000000

//--- tb.f
logic/csr_map_pkg.sv
logic/trap_pkg.sv
logic/csr_regs.sv
logic/csr_read_mux.sv
logic/trap_ctrl.sv
logic/csr_unit.sv
verif/csr_checker.sv
verif/csr_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing
TOP       = csr_tb
FILELIST  = tb.f
BUILD     = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "\*\*\* TEST PASSED \*\*\*" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
